/* project.f */
qsim_pkg.sv
qsim_ctrl_fsm.sv
qsim_loop_counters.sv
qsim_addr_gen.sv
qsim_complex_mac.sv
qsim_top.sv
tb_clock_gen.sv
tb_qsim.sv

/* qsim_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module qsim_addr_gen #(
  parameter int MAX_QUBITS = 3
) (
  input  logic                          clk,
  input  logic                          reset_n,
  input  qsim_pkg::ctrl_t               ctrl,
  input  qsim_pkg::flags_t              flags,
  input  logic [MAX_QUBITS-1:0]         col,
  input  logic [MAX_QUBITS-1:0]         row,
  input  logic [qsim_pkg::FIELD_W-1:0]  gate,
  input  logic [MAX_QUBITS:0]           vec_len,
  output logic [qsim_pkg::ADDR_W-1:0]   in_rd_addr,
  output logic [qsim_pkg::ADDR_W-1:0]   gate_rd_addr,
  output logic [qsim_pkg::ADDR_W-1:0]   scratch_rd_addr,
  output logic [qsim_pkg::ADDR_W-1:0]   scratch_wr_addr,
  output logic [qsim_pkg::ADDR_W-1:0]   out_wr_addr,
  output logic                          scratch_we,
  output logic                          out_we,
  output logic                          use_scratch
);
  import qsim_pkg::*;

  localparam int WR_DLY = 3;  // stages ahead of the write register

  typedef struct packed {
    logic              to_out;  // last gate, row goes to output sram
    logic [ADDR_W-1:0] addr;
  } wr_slot_t;

  logic [ADDR_W-1:0] n, c, r, g;
  logic [ADDR_W-1:0] gate_addr, vec_addr, wr_addr;
  logic [WR_DLY-1:0] wr_vld;
  wr_slot_t          wr_pipe [WR_DLY];
  logic [ADDR_W-1:0] wr_addr_q;
  logic              scr_d1;

  assign n = ADDR_W'(vec_len);
  assign c = ADDR_W'(col);
  assign r = ADDR_W'(row);
  assign g = ADDR_W'(gate);

  assign gate_addr = g * n * n + r * n + c;     // row-major, gates back to back
  assign vec_addr  = (g - 1'b1) * n + c;        // previous gate's result
  assign wr_addr   = flags.gate_last ? r : g * n + r;

  // ------------------------------
  // read side
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      in_rd_addr      <= '0;
      gate_rd_addr    <= '0;
      scratch_rd_addr <= '0;
      scr_d1          <= 1'b0;
      use_scratch     <= 1'b0;
    end else begin
      in_rd_addr <= ctrl.issue_rd ? c + 1'b1 : '0;  // rests on the header word
      if (ctrl.issue_rd) begin
        gate_rd_addr    <= gate_addr;
        scratch_rd_addr <= vec_addr;
      end
      scr_d1      <= (g != '0);
      use_scratch <= scr_d1;  // lines up with read data
    end
  end

  // ------------------------------
  // write side, follows the mac
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_vld     <= '0;
      scratch_we <= 1'b0;
      out_we     <= 1'b0;
    end else begin
      wr_vld     <= {wr_vld[WR_DLY-2:0], ctrl.write_row};
      scratch_we <= wr_vld[WR_DLY-1] & ~wr_pipe[WR_DLY-1].to_out;
      out_we     <= wr_vld[WR_DLY-1] & wr_pipe[WR_DLY-1].to_out;
    end
  end

  always_ff @(posedge clk) begin
    wr_pipe[0].to_out <= flags.gate_last;
    wr_pipe[0].addr   <= wr_addr;
    for (int i = 1; i < WR_DLY; i++) begin
      wr_pipe[i] <= wr_pipe[i-1];
    end
    wr_addr_q <= wr_pipe[WR_DLY-1].addr;
  end

  assign scratch_wr_addr = wr_addr_q;
  assign out_wr_addr     = wr_addr_q;

  a_one_dest: assert property (@(posedge clk) disable iff (!reset_n)
    !(scratch_we && out_we))
    else $error("row written to scratchpad and output at once");

endmodule

`default_nettype wire

/* qsim_complex_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module qsim_complex_mac (
  input  logic                  clk,
  input  logic                  reset_n,
  input  qsim_pkg::ctrl_t       ctrl,
  input  logic                  use_scratch,
  input  qsim_pkg::state_word_u in_rd_data,
  input  qsim_pkg::cplx_t       scratch_rd_data,
  input  qsim_pkg::cplx_t       gate_rd_data,
  output qsim_pkg::cplx_t       wr_data
);
  import qsim_pkg::*;

  cplx_t                      b_op;
  logic signed [2*COMP_W-1:0] p_rr, p_ii, p_ri, p_ir;
  acc_t                       prod_q;
  acc_t                       acc_q;
  logic [2:0]                 vld_sr;  // issue_rd, aligned to accumulate
  logic [2:0]                 clr_sr;

  // gate 0 takes the input vector, later gates the scratchpad
  assign b_op = use_scratch ? scratch_rd_data : in_rd_data.smp;

  assign p_rr = gate_rd_data.re * b_op.re;
  assign p_ii = gate_rd_data.im * b_op.im;
  assign p_ri = gate_rd_data.re * b_op.im;
  assign p_ir = gate_rd_data.im * b_op.re;

  // ------------------------------
  // control alignment
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      vld_sr <= '0;
      clr_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[1:0], ctrl.issue_rd};
      clr_sr <= {clr_sr[1:0], ctrl.clr_acc};
    end
  end

  // ------------------------------
  // product stage and accumulator
  // ------------------------------
  always_ff @(posedge clk) begin
    prod_q.re <= p_rr - p_ii;  // sign extended to ACC_W
    prod_q.im <= p_ri + p_ir;
    if (vld_sr[2]) begin
      if (clr_sr[2]) begin
        acc_q <= prod_q;  // new row
      end else begin
        acc_q.re <= acc_q.re + prod_q.re;
        acc_q.im <= acc_q.im + prod_q.im;
      end
    end
  end

  // >>> FRAC_BITS, keep the low COMP_W bits
  assign wr_data.re = acc_q.re[FRAC_BITS +: COMP_W];
  assign wr_data.im = acc_q.im[FRAC_BITS +: COMP_W];

endmodule

`default_nettype wire

/* qsim_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module qsim_ctrl_fsm (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             dut_valid,
  output logic             dut_ready,
  input  qsim_pkg::flags_t flags,
  output qsim_pkg::ctrl_t  ctrl
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_RD_HDR,
    S_LOAD,
    S_RUN,
    S_DRAIN,
    S_WRITE
  } state_t;

  // product reg, accumulate, write reg
  localparam logic [1:0] DRAIN_LAST = 2'd2;

  state_t     state;
  state_t     next_state;
  logic [1:0] drain_cnt;
  logic       row_start;  // current RUN cycle is column 0

  // ------------------------------
  // state register
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state     <= S_IDLE;
      drain_cnt <= 2'd0;
      row_start <= 1'b0;
    end else begin
      state     <= next_state;
      row_start <= ctrl.clr_col;
      drain_cnt <= (state == S_DRAIN) ? drain_cnt + 2'd1 : 2'd0;
    end
  end

  always_comb begin
    next_state = state;
    ctrl       = '0;
    case (state)
      S_IDLE: begin
        if (dut_valid) next_state = S_RD_HDR;
      end
      S_RD_HDR: next_state = S_LOAD;  // input address parked at 0
      S_LOAD: begin
        ctrl.load_dims = 1'b1;
        ctrl.clr_col   = 1'b1;
        ctrl.clr_row   = 1'b1;
        ctrl.clr_gate  = 1'b1;
        next_state     = S_RUN;
      end
      S_RUN: begin
        ctrl.issue_rd = 1'b1;
        ctrl.clr_acc  = row_start;
        if (flags.col_last) begin
          ctrl.write_row = 1'b1;
          ctrl.clr_col   = 1'b1;
          if (flags.row_last) begin
            next_state = S_DRAIN;
          end else begin
            ctrl.step_row = 1'b1;  // next row starts without a gap
          end
        end else begin
          ctrl.step_col = 1'b1;
        end
      end
      // let the final row land before the next gate reads it
      S_DRAIN: begin
        if (drain_cnt == DRAIN_LAST) next_state = S_WRITE;
      end
      S_WRITE: begin
        if (flags.gate_last) begin
          next_state = S_IDLE;
        end else begin
          ctrl.step_gate = 1'b1;
          ctrl.clr_row   = 1'b1;
          ctrl.clr_col   = 1'b1;
          next_state     = S_RUN;
        end
      end
      default: next_state = S_IDLE;
    endcase
  end

  assign dut_ready = (state == S_IDLE);

  // a row's last product and the next row's first clear come from different cycles
  a_wr_clr_excl: assert property (@(posedge clk) disable iff (!reset_n)
    !(ctrl.write_row && ctrl.clr_acc))
    else $error("write_row and clr_acc asserted together");

endmodule

`default_nettype wire

/* qsim_loop_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module qsim_loop_counters #(
  parameter int MAX_QUBITS = 3
) (
  input  logic                           clk,
  input  logic                           reset_n,
  input  qsim_pkg::ctrl_t                ctrl,
  input  qsim_pkg::header_t              header,
  output qsim_pkg::flags_t               flags,
  output logic [MAX_QUBITS-1:0]          col,
  output logic [MAX_QUBITS-1:0]          row,
  output logic [qsim_pkg::FIELD_W-1:0]   gate,
  output logic [MAX_QUBITS:0]            vec_len
);
  import qsim_pkg::*;

  localparam int VEC_W = MAX_QUBITS + 1;

  logic [FIELD_W-1:0] num_gates_q;
  logic [VEC_W-1:0]   last_idx;

  // ------------------------------
  // dimensions from the header
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      vec_len     <= VEC_W'(1);
      num_gates_q <= FIELD_W'(1);
    end else if (ctrl.load_dims) begin
      vec_len     <= VEC_W'(1) << header.num_qubits;  // 2^q
      num_gates_q <= header.num_gates;
    end
  end

  // ------------------------------
  // loop counters
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      col  <= '0;
      row  <= '0;
      gate <= '0;
    end else begin
      if (ctrl.clr_col) col <= '0;
      else if (ctrl.step_col) col <= col + 1'b1;
      if (ctrl.clr_row) row <= '0;
      else if (ctrl.step_row) row <= row + 1'b1;
      if (ctrl.clr_gate) gate <= '0;
      else if (ctrl.step_gate) gate <= gate + 1'b1;
    end
  end

  assign last_idx        = vec_len - 1'b1;
  assign flags.col_last  = ({1'b0, col} == last_idx);
  assign flags.row_last  = ({1'b0, row} == last_idx);
  assign flags.gate_last = (gate == num_gates_q - 1'b1);

  a_dims_legal: assert property (@(posedge clk) disable iff (!reset_n)
    ctrl.load_dims |-> (header.num_qubits >= 1 && header.num_qubits <= MAX_QUBITS
                        && header.num_gates != 0))
    else $error("unsupported header q=%0d m=%0d", header.num_qubits, header.num_gates);

  // fsm must clear col on the flag, never run past it
  a_col_range: assert property (@(posedge clk) disable iff (!reset_n)
    {1'b0, col} <= last_idx)
    else $error("col %0d beyond vector length %0d", col, vec_len);

endmodule

`default_nettype wire

/* qsim_pkg.sv */
`default_nettype none

package qsim_pkg;

  // ------------------------------
  // widths and number format
  // ------------------------------
  localparam int DATA_W    = 32;  // one sram word
  localparam int ADDR_W    = 16;
  localparam int COMP_W    = 16;  // re or im
  localparam int FRAC_BITS = 14;  // signed q1.14
  localparam int ACC_W     = 40;  // per component, full precision
  localparam int FIELD_W   = 16;  // header fields and gate count

  // one complex sample or matrix entry
  typedef struct packed {
    logic signed [COMP_W-1:0] re;
    logic signed [COMP_W-1:0] im;
  } cplx_t;

  typedef struct packed {
    logic [FIELD_W-1:0] num_qubits;
    logic [FIELD_W-1:0] num_gates;
  } header_t;

  // input sram word, header at address 0 and amplitudes above it
  typedef union packed {
    header_t hdr;
    cplx_t   smp;
  } state_word_u;

  typedef struct packed {
    logic signed [ACC_W-1:0] re;
    logic signed [ACC_W-1:0] im;
  } acc_t;

  // ------------------------------
  // fsm commands and loop flags
  // ------------------------------
  typedef struct packed {
    logic load_dims;
    logic clr_col;
    logic step_col;
    logic clr_row;
    logic step_row;
    logic clr_gate;
    logic step_gate;
    logic issue_rd;   // one matrix/vector read pair
    logic clr_acc;    // first product of a row
    logic write_row;  // marks the last column of a row
  } ctrl_t;

  typedef struct packed {
    logic col_last;
    logic row_last;
    logic gate_last;
  } flags_t;

endpackage

`default_nettype wire

/* qsim_top.sv */
`timescale 1ns/1ps
`default_nettype none

module qsim_top #(
  parameter int MAX_QUBITS = 3
) (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         dut_valid,
  output logic                         dut_ready,
  // input state sram
  output logic [qsim_pkg::ADDR_W-1:0]  in_rd_addr,
  input  logic [qsim_pkg::DATA_W-1:0]  in_rd_data,
  // gate sram
  output logic [qsim_pkg::ADDR_W-1:0]  gate_rd_addr,
  input  logic [qsim_pkg::DATA_W-1:0]  gate_rd_data,
  // scratchpad sram
  output logic [qsim_pkg::ADDR_W-1:0]  scratch_rd_addr,
  input  logic [qsim_pkg::DATA_W-1:0]  scratch_rd_data,
  output logic [qsim_pkg::ADDR_W-1:0]  scratch_wr_addr,
  output logic [qsim_pkg::DATA_W-1:0]  scratch_wr_data,
  output logic                         scratch_we,
  // output state sram
  output logic [qsim_pkg::ADDR_W-1:0]  out_wr_addr,
  output logic [qsim_pkg::DATA_W-1:0]  out_wr_data,
  output logic                         out_we
);
  import qsim_pkg::*;

  ctrl_t                 ctrl;
  flags_t                flags;
  state_word_u           in_word;
  cplx_t                 gate_word;
  cplx_t                 scratch_word;
  cplx_t                 row_data;
  logic [MAX_QUBITS-1:0] col;
  logic [MAX_QUBITS-1:0] row;
  logic [FIELD_W-1:0]    gate;
  logic [MAX_QUBITS:0]   vec_len;
  logic                  use_scratch;

  assign in_word      = in_rd_data;
  assign gate_word    = gate_rd_data;
  assign scratch_word = scratch_rd_data;

  // same row result, destination picked by the write enables
  assign scratch_wr_data = row_data;
  assign out_wr_data     = row_data;

  // ------------------------------
  // control
  // ------------------------------
  qsim_ctrl_fsm i_ctrl_fsm (
    .clk       (clk),
    .reset_n   (reset_n),
    .dut_valid (dut_valid),
    .dut_ready (dut_ready),
    .flags     (flags),
    .ctrl      (ctrl)
  );

  qsim_loop_counters #(.MAX_QUBITS(MAX_QUBITS)) i_loop_counters (
    .clk     (clk),
    .reset_n (reset_n),
    .ctrl    (ctrl),
    .header  (in_word.hdr),
    .flags   (flags),
    .col     (col),
    .row     (row),
    .gate    (gate),
    .vec_len (vec_len)
  );

  // ------------------------------
  // datapath
  // ------------------------------
  qsim_addr_gen #(.MAX_QUBITS(MAX_QUBITS)) i_addr_gen (
    .clk             (clk),
    .reset_n         (reset_n),
    .ctrl            (ctrl),
    .flags           (flags),
    .col             (col),
    .row             (row),
    .gate            (gate),
    .vec_len         (vec_len),
    .in_rd_addr      (in_rd_addr),
    .gate_rd_addr    (gate_rd_addr),
    .scratch_rd_addr (scratch_rd_addr),
    .scratch_wr_addr (scratch_wr_addr),
    .out_wr_addr     (out_wr_addr),
    .scratch_we      (scratch_we),
    .out_we          (out_we),
    .use_scratch     (use_scratch)
  );

  qsim_complex_mac i_complex_mac (
    .clk             (clk),
    .reset_n         (reset_n),
    .ctrl            (ctrl),
    .use_scratch     (use_scratch),
    .in_rd_data      (in_word),
    .scratch_rd_data (scratch_word),
    .gate_rd_data    (gate_word),
    .wr_data         (row_data)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the qsim testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_qsim -Mdir obj_dir -o sim_qsim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_qsim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi
exit 0

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // sync reset, held low for a few rising edges
  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* tb_qsim.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_qsim;
  import qsim_pkg::*;

  localparam int MAX_QUBITS = 3;
  localparam int MAX_N      = 1 << MAX_QUBITS;
  localparam int MEM_DEPTH  = 256;
  localparam int NUM_RUNS   = 7;
  localparam logic [31:0] SEED = 32'hbd92_dd24;
  // run sizes; the last two belong to the held-valid test
  localparam int RUN_Q [NUM_RUNS] = '{1, 2, 3, 3, 3, 2, 2};
  localparam int RUN_G [NUM_RUNS] = '{1, 3, 1, 2, 2, 1, 1};

  logic clk, reset_n, dut_valid, dut_ready;
  logic [ADDR_W-1:0] in_rd_addr, gate_rd_addr, scratch_rd_addr, scratch_wr_addr, out_wr_addr;
  logic [DATA_W-1:0] in_rd_data = '0;
  logic [DATA_W-1:0] gate_rd_data = '0;
  logic [DATA_W-1:0] scratch_rd_data = '0;
  logic [DATA_W-1:0] scratch_wr_data, out_wr_data;
  logic              scratch_we, out_we;

  logic [DATA_W-1:0] in_mem      [MEM_DEPTH];
  logic [DATA_W-1:0] gate_mem    [MEM_DEPTH];
  logic [DATA_W-1:0] scratch_mem [MEM_DEPTH];
  logic [DATA_W-1:0] out_mem     [MEM_DEPTH];
  logic              clear_out;
  cplx_t             exp_vec [MAX_N];
  int                out_writes = 0;
  int                run_starts = 0;
  logic              ready_d = 1'b0;
  int                cmp_req = 0;
  int                cmp_done = 0;
  int                cur_n = 0;

  tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(2)) i_clock_gen (.clk(clk), .reset_n(reset_n));

  qsim_top #(.MAX_QUBITS(MAX_QUBITS)) i_dut (.*);

  // ------------------------------
  // sram models with one cycle read
  // ------------------------------
  always @(posedge clk) begin
    in_rd_data      <= in_mem[in_rd_addr[7:0]];
    gate_rd_data    <= gate_mem[gate_rd_addr[7:0]];
    scratch_rd_data <= scratch_mem[scratch_rd_addr[7:0]];
    if (scratch_we) begin
      if (scratch_wr_addr >= ADDR_W'(MEM_DEPTH)) fail_run("scratchpad write out of range");
      scratch_mem[scratch_wr_addr[7:0]] <= scratch_wr_data;
    end
    if (clear_out) begin
      for (int i = 0; i < MEM_DEPTH; i++) out_mem[i] <= {~16'(i), 16'(i)};
    end else if (out_we) begin
      if (out_wr_addr >= ADDR_W'(MEM_DEPTH)) fail_run("output write out of range");
      out_mem[out_wr_addr[7:0]] <= out_wr_data;
    end
  end

  // write and start counters
  always @(negedge clk) begin
    if (reset_n) begin
      if (out_we) out_writes <= out_writes + 1;
      if (ready_d && !dut_ready) run_starts <= run_starts + 1;
    end
    ready_d <= dut_ready;
  end

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  function automatic logic [COMP_W-1:0] rand_comp();
    int v;
    v = int'($urandom % 32'd16385) - 8192;  // -8192 .. 8192
    return COMP_W'(v);
  endfunction

  // fixed-point chain with a full sum per row then >>> 14 down to 16 bits
  function automatic void compute_expected(int nq, int ng);
    cplx_t  vec [MAX_N];
    cplx_t  nxt [MAX_N];
    cplx_t  a;
    cplx_t  b;
    longint acc_re;
    longint acc_im;
    int     n;
    n = 1 << nq;
    for (int i = 0; i < n; i++) vec[i] = in_mem[i + 1];
    for (int g = 0; g < ng; g++) begin
      for (int r = 0; r < n; r++) begin
        acc_re = 0;
        acc_im = 0;
        for (int c = 0; c < n; c++) begin
          a = gate_mem[g * n * n + r * n + c];
          b = vec[c];
          acc_re += longint'(a.re) * longint'(b.re) - longint'(a.im) * longint'(b.im);
          acc_im += longint'(a.re) * longint'(b.im) + longint'(a.im) * longint'(b.re);
        end
        nxt[r].re = COMP_W'(acc_re >>> FRAC_BITS);
        nxt[r].im = COMP_W'(acc_im >>> FRAC_BITS);
      end
      for (int i = 0; i < n; i++) vec[i] = nxt[i];
    end
    for (int i = 0; i < n; i++) exp_vec[i] = vec[i];
  endfunction

  function automatic int cycle_budget();
    int total;
    int n;
    total = 0;
    for (int i = 0; i < NUM_RUNS; i++) begin
      n = 1 << RUN_Q[i];
      total += 4 * (n + 2) * n * RUN_G[i] + 50;
    end
    return total;
  endfunction

  task automatic load_memories(int nq, int ng);
    header_t hdr;
    int      n;
    n = 1 << nq;
    hdr.num_qubits = FIELD_W'(nq);
    hdr.num_gates  = FIELD_W'(ng);
    @(posedge clk);
    in_mem[0] <= hdr;
    for (int i = 0; i < n; i++) in_mem[i + 1] <= {rand_comp(), rand_comp()};
    for (int i = 0; i < ng * n * n; i++) gate_mem[i] <= {rand_comp(), rand_comp()};
    clear_out <= 1'b1;  // stale rows must not pass
    @(posedge clk);
    clear_out <= 1'b0;
  endtask

  task automatic wait_run_end();
    @(negedge clk);
    while (dut_ready) @(negedge clk);
    while (!dut_ready) @(negedge clk);
  endtask

  task automatic compare_output(int n);
    cur_n = n;
    cmp_req++;
    wait (cmp_done == cmp_req);
  endtask

  task automatic run_case(int nq, int ng);
    int n;
    int w0;
    n = 1 << nq;
    load_memories(nq, ng);
    compute_expected(nq, ng);
    w0 = out_writes;
    dut_valid <= 1'b1;
    @(posedge clk);
    dut_valid <= 1'b0;
    wait_run_end();
    check_value("out_we count", DATA_W'(out_writes - w0), DATA_W'(n));
    compare_output(n);
  endtask

  // ------------------------------
  // compare process
  // ------------------------------
  initial begin
    forever begin
      wait (cmp_req != cmp_done);
      for (int i = 0; i < cur_n; i++) begin
        check_value($sformatf("out_mem[%0d]", i), out_mem[i], exp_vec[i]);
      end
      cmp_done = cmp_req;
    end
  end

  initial begin
    repeat (cycle_budget()) @(posedge clk);
    fail_run("timeout: the DUT did not finish all runs within the cycle budget");
  end

  initial begin
    int n;
    int w0;
    int s0;
    dut_valid = 1'b0;
    clear_out = 1'b0;
    void'($urandom(SEED));
    wait (reset_n === 1'b1);
    @(negedge clk);
    check_value("dut_ready", DATA_W'(dut_ready), 32'd1);
    check_value("out_we", DATA_W'(out_we), 32'd0);
    check_value("scratch_we", DATA_W'(scratch_we), 32'd0);

    for (int t = 0; t < 5; t++) run_case(RUN_Q[t], RUN_G[t]);  // last two back to back

    // valid held high through a whole run
    n = 1 << RUN_Q[5];
    load_memories(RUN_Q[5], RUN_G[5]);
    compute_expected(RUN_Q[5], RUN_G[5]);
    w0 = out_writes;
    s0 = run_starts;
    dut_valid <= 1'b1;
    wait_run_end();
    @(posedge clk);  // ready is back and valid still high, so the second run starts here
    dut_valid <= 1'b0;
    @(negedge clk);
    while (!dut_ready) @(negedge clk);
    check_value("run_starts", DATA_W'(run_starts - s0), 32'd2);
    check_value("out_we count", DATA_W'(out_writes - w0), DATA_W'(2 * n));
    compare_output(n);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire
